//--- Makefile
TOP = tb_cpu7_csr_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f cpu7_csr.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f cpu7_csr.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cpu7_csr.f
hdl/cpu7_csr_pkg.sv
hdl/cpu7_csr_access.sv
hdl/cpu7_excp.sv
hdl/cpu7_csr.sv
hdl/cpu7_csr_top.sv
sim/tb_cpu7_csr_top.sv

//--- hdl/cpu7_csr.sv
`timescale 1ns/1ps

module cpu7_csr (
   input  logic                                  clk,
   input  logic                                  reset,

   // instruction access
   input  logic [cpu7_csr_pkg::CSR_NUM_W-1:0]    csr_raddr,
   input  logic [cpu7_csr_pkg::CSR_NUM_W-1:0]    csr_waddr,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        csr_wdata,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        csr_mask,
   input  logic                                  csr_wen,

   // execute stage commits
   input  logic                                  excp_commit,
   input  logic                                  ertn_commit,
   input  logic [cpu7_csr_pkg::ECODE_W-1:0]      excp_ecode,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        pc_e,

   output logic [cpu7_csr_pkg::GRLEN-1:0]        csr_rdata,
   output logic [cpu7_csr_pkg::GRLEN-1:0]        csr_eentry,
   output logic [cpu7_csr_pkg::GRLEN-1:0]        csr_era,
   output logic                                  eeprom_flush
);

   import cpu7_csr_pkg::*;

   // register fields
   logic                        crmd_ie;
   logic [PLV_W-1:0]            crmd_plv;
   logic                        prmd_pie;
   logic [PLV_W-1:0]            prmd_pplv;
   logic [ECODE_W-1:0]          estat_ecode;
   logic [GRLEN-1:0]            era;
   logic [GRLEN-1:EENTRY_VA_LO] eentry_va;
   logic                        bsec_ef;

   // per register write selects
   logic crmd_we;
   logic prmd_we;
   logic estat_we;
   logic era_we;
   logic eentry_we;
   logic bsec_we;

   assign crmd_we   = csr_wen && (csr_waddr == CSR_CRMD);
   assign prmd_we   = csr_wen && (csr_waddr == CSR_PRMD);
   assign estat_we  = csr_wen && (csr_waddr == CSR_ESTAT);
   assign era_we    = csr_wen && (csr_waddr == CSR_ERA);
   assign eentry_we = csr_wen && (csr_waddr == CSR_EENTRY);
   assign bsec_we   = csr_wen && (csr_waddr == CSR_BSEC);

   // masked write values, old bits kept where the mask is clear
   logic                        crmd_ie_wr;
   logic [PLV_W-1:0]            crmd_plv_wr;
   logic                        prmd_pie_wr;
   logic [PLV_W-1:0]            prmd_pplv_wr;
   logic [ECODE_W-1:0]          estat_ecode_wr;
   logic [GRLEN-1:0]            era_wr;
   logic [GRLEN-1:EENTRY_VA_LO] eentry_va_wr;

   assign crmd_ie_wr = (crmd_ie & ~csr_mask[CRMD_IE]) |
                       (csr_wdata[CRMD_IE] & csr_mask[CRMD_IE]);
   assign crmd_plv_wr = (crmd_plv & ~csr_mask[CRMD_PLV_LO +: PLV_W]) |
                        (csr_wdata[CRMD_PLV_LO +: PLV_W] & csr_mask[CRMD_PLV_LO +: PLV_W]);

   assign prmd_pie_wr = (prmd_pie & ~csr_mask[PRMD_PIE]) |
                        (csr_wdata[PRMD_PIE] & csr_mask[PRMD_PIE]);
   assign prmd_pplv_wr = (prmd_pplv & ~csr_mask[PRMD_PPLV_LO +: PLV_W]) |
                         (csr_wdata[PRMD_PPLV_LO +: PLV_W] &
                          csr_mask[PRMD_PPLV_LO +: PLV_W]);

   assign estat_ecode_wr = (estat_ecode & ~csr_mask[ESTAT_ECODE_LO +: ECODE_W]) |
                           (csr_wdata[ESTAT_ECODE_LO +: ECODE_W] &
                            csr_mask[ESTAT_ECODE_LO +: ECODE_W]);

   assign era_wr = (era & ~csr_mask) | (csr_wdata & csr_mask);

   assign eentry_va_wr = (eentry_va & ~csr_mask[GRLEN-1:EENTRY_VA_LO]) |
                         (csr_wdata[GRLEN-1:EENTRY_VA_LO] & csr_mask[GRLEN-1:EENTRY_VA_LO]);

   // crmd: exception clears, ertn restores from prmd
   always_ff @(posedge clk) begin
      if (reset) begin
         crmd_ie  <= 1'b0;
         crmd_plv <= '0;
      end else if (excp_commit) begin
         crmd_ie  <= 1'b0;
         crmd_plv <= '0;
      end else if (ertn_commit) begin
         crmd_ie  <= prmd_pie;
         crmd_plv <= prmd_pplv;
      end else if (crmd_we) begin
         crmd_ie  <= crmd_ie_wr;
         crmd_plv <= crmd_plv_wr;
      end
   end

   // prmd saves the crmd state on exception entry
   always_ff @(posedge clk) begin
      if (reset) begin
         prmd_pie  <= 1'b0;
         prmd_pplv <= '0;
      end else if (excp_commit) begin
         prmd_pie  <= crmd_ie;
         prmd_pplv <= crmd_plv;
      end else if (prmd_we) begin
         prmd_pie  <= prmd_pie_wr;
         prmd_pplv <= prmd_pplv_wr;
      end
   end

   // exception cause and return address
   always_ff @(posedge clk) begin
      if (reset) begin
         estat_ecode <= '0;
         era         <= '0;
      end else if (excp_commit) begin
         estat_ecode <= excp_ecode;
         era         <= pc_e;
      end else begin
         if (estat_we) begin
            estat_ecode <= estat_ecode_wr;
         end
         if (era_we) begin
            era <= era_wr;
         end
      end
   end

   // eentry changes only by software
   always_ff @(posedge clk) begin
      if (reset) begin
         eentry_va <= '0;
      end else if (eentry_we) begin
         eentry_va <= eentry_va_wr;
      end
   end

   // sticky flush request, writing 0 has no effect
   always_ff @(posedge clk) begin
      if (reset) begin
         bsec_ef <= 1'b0;
      end else if (bsec_we && csr_mask[BSEC_EF] && csr_wdata[BSEC_EF]) begin
         bsec_ef <= 1'b1;
      end
   end

   assign csr_era      = era;
   assign csr_eentry   = {eentry_va, {EENTRY_VA_LO{1'b0}}};
   assign eeprom_flush = bsec_ef;

   // read mux, unimplemented bits and numbers read as zero
   always_comb begin
      csr_rdata = '0;
      case (csr_raddr)
         CSR_CRMD: begin
            csr_rdata[CRMD_IE]                 = crmd_ie;
            csr_rdata[CRMD_PLV_LO +: PLV_W]    = crmd_plv;
         end
         CSR_PRMD: begin
            csr_rdata[PRMD_PIE]                = prmd_pie;
            csr_rdata[PRMD_PPLV_LO +: PLV_W]   = prmd_pplv;
         end
         CSR_ESTAT:  csr_rdata[ESTAT_ECODE_LO +: ECODE_W] = estat_ecode;
         CSR_ERA:    csr_rdata = era;
         CSR_EENTRY: csr_rdata = csr_eentry;
         CSR_BSEC:   csr_rdata[BSEC_EF] = bsec_ef;
         default:    csr_rdata = '0;
      endcase
   end

   // access block must squash writes under an exception
   a_no_write_on_excp: assert property (
      @(posedge clk) disable iff (reset)
      !(csr_wen && excp_commit)
   ) else $error("csr write enabled during exception commit");

endmodule

//--- hdl/cpu7_csr_access.sv
`timescale 1ns/1ps

module cpu7_csr_access (
   input  logic                                csr_op_valid,
   input  logic [cpu7_csr_pkg::CSR_OP_W-1:0]   csr_op,
   input  logic [cpu7_csr_pkg::CSR_NUM_W-1:0]  csr_num,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]      csr_rd_value,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]      csr_rj_value,
   input  logic                                squash,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]      csr_rdata,

   output logic [cpu7_csr_pkg::CSR_NUM_W-1:0]  csr_raddr,
   output logic [cpu7_csr_pkg::CSR_NUM_W-1:0]  csr_waddr,
   output logic [cpu7_csr_pkg::GRLEN-1:0]      csr_wdata,
   output logic [cpu7_csr_pkg::GRLEN-1:0]      csr_mask,
   output logic                                csr_wen,
   output logic [cpu7_csr_pkg::GRLEN-1:0]      csr_result
);

   import cpu7_csr_pkg::*;

   logic op_wr;
   logic op_xchg;

   // op decode, csrrd needs no write side
   assign op_wr   = csr_op_valid && (csr_op == CSR_OP_WR);
   assign op_xchg = csr_op_valid && (csr_op == CSR_OP_XCHG);

   // the same csr is read and written by one instruction
   assign csr_raddr = csr_num;
   assign csr_waddr = csr_num;

   // write data always comes from rd
   assign csr_wdata = csr_rd_value;

   // csrxchg writes only where rj has ones
   // csrwr writes the whole register
   assign csr_mask = op_xchg ? csr_rj_value : {GRLEN{1'b1}};

   // an exception in the same cycle kills the write
   assign csr_wen = (op_wr || op_xchg) && !squash;

   // all three ops return the value before the write
   assign csr_result = csr_rdata;

   // decode only ever sees the three defined ops
   always_comb begin
      if (csr_op_valid) begin
         a_op_not_reserved: assert (csr_op inside {CSR_OP_RD, CSR_OP_WR, CSR_OP_XCHG})
            else $error("csr op %0d is reserved", csr_op);
      end
   end

endmodule

//--- hdl/cpu7_csr_pkg.sv
package cpu7_csr_pkg;

   // datapath width
   localparam int GRLEN = 32;

   // csr number width as carried in the instruction
   localparam int CSR_NUM_W = 14;

   // implemented csr numbers
   localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
   localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
   localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
   localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
   localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
   // self-defined boot security register
   localparam logic [CSR_NUM_W-1:0] CSR_BSEC   = 14'h100;

   // privilege level field width
   localparam int PLV_W = 2;

   // crmd fields
   localparam int CRMD_PLV_LO = 0;
   localparam int CRMD_IE     = 2;

   // prmd fields, same layout as crmd
   localparam int PRMD_PPLV_LO = 0;
   localparam int PRMD_PIE     = 2;

   // estat exception code field
   localparam int ESTAT_ECODE_LO = 16;
   localparam int ECODE_W        = 6;

   // eentry is 64-byte aligned
   localparam int EENTRY_VA_LO = 6;

   // bsec eeprom flush request
   localparam int BSEC_EF = 0;

   // csr instruction op field
   localparam int CSR_OP_W = 2;

   localparam logic [CSR_OP_W-1:0] CSR_OP_RD   = 2'd0;
   localparam logic [CSR_OP_W-1:0] CSR_OP_WR   = 2'd1;
   localparam logic [CSR_OP_W-1:0] CSR_OP_XCHG = 2'd2;
   // 2'd3 is reserved

   // exception codes written into estat.ecode
   // address error
   localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h09;
   // illegal instruction
   localparam logic [ECODE_W-1:0] ECODE_INE = 6'h0d;

endpackage

//--- hdl/cpu7_csr_top.sv
`timescale 1ns/1ps

module cpu7_csr_top (
   input  logic                                  clk,
   input  logic                                  reset,

   // csr instruction from execute
   input  logic                                  csr_op_valid,
   input  logic [cpu7_csr_pkg::CSR_OP_W-1:0]     csr_op,
   input  logic [cpu7_csr_pkg::CSR_NUM_W-1:0]    csr_num,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        csr_rd_value,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        csr_rj_value,

   // exception and ertn flags from execute
   input  logic                                  ale_e,
   input  logic                                  illinst_e,
   input  logic                                  ertn_e,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        pc_e,

   output logic [cpu7_csr_pkg::GRLEN-1:0]        csr_result,
   output logic                                  redirect_valid,
   output logic [cpu7_csr_pkg::GRLEN-1:0]        redirect_pc,
   output logic                                  eeprom_flush
);

   import cpu7_csr_pkg::*;

   // access to csr file
   logic [CSR_NUM_W-1:0] csr_raddr;
   logic [CSR_NUM_W-1:0] csr_waddr;
   logic [GRLEN-1:0]     csr_wdata;
   logic [GRLEN-1:0]     csr_mask;
   logic                 csr_wen;
   logic [GRLEN-1:0]     csr_rdata;

   // exception unit to csr file and access
   logic                 excp_commit;
   logic                 ertn_commit;
   logic                 squash;
   logic [ECODE_W-1:0]   excp_ecode;

   // redirect targets
   logic [GRLEN-1:0]     csr_eentry;
   logic [GRLEN-1:0]     csr_era;

   cpu7_csr_access i_cpu7_csr_access (
      .csr_op_valid (csr_op_valid),
      .csr_op       (csr_op),
      .csr_num      (csr_num),
      .csr_rd_value (csr_rd_value),
      .csr_rj_value (csr_rj_value),
      .squash       (squash),
      .csr_rdata    (csr_rdata),
      .csr_raddr    (csr_raddr),
      .csr_waddr    (csr_waddr),
      .csr_wdata    (csr_wdata),
      .csr_mask     (csr_mask),
      .csr_wen      (csr_wen),
      .csr_result   (csr_result)
   );

   cpu7_excp i_cpu7_excp (
      .clk            (clk),
      .reset          (reset),
      .ale_e          (ale_e),
      .illinst_e      (illinst_e),
      .ertn_e         (ertn_e),
      .csr_eentry     (csr_eentry),
      .csr_era        (csr_era),
      .excp_commit    (excp_commit),
      .ertn_commit    (ertn_commit),
      .squash         (squash),
      .excp_ecode     (excp_ecode),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

   cpu7_csr i_cpu7_csr (
      .clk          (clk),
      .reset        (reset),
      .csr_raddr    (csr_raddr),
      .csr_waddr    (csr_waddr),
      .csr_wdata    (csr_wdata),
      .csr_mask     (csr_mask),
      .csr_wen      (csr_wen),
      .excp_commit  (excp_commit),
      .ertn_commit  (ertn_commit),
      .excp_ecode   (excp_ecode),
      .pc_e         (pc_e),
      .csr_rdata    (csr_rdata),
      .csr_eentry   (csr_eentry),
      .csr_era      (csr_era),
      .eeprom_flush (eeprom_flush)
   );

endmodule

//--- hdl/cpu7_excp.sv
`timescale 1ns/1ps

module cpu7_excp (
   input  logic                                  clk,
   input  logic                                  reset,

   // execute stage event flags
   input  logic                                  ale_e,
   input  logic                                  illinst_e,
   input  logic                                  ertn_e,

   // redirect targets from the csr file
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        csr_eentry,
   input  logic [cpu7_csr_pkg::GRLEN-1:0]        csr_era,

   output logic                                  excp_commit,
   output logic                                  ertn_commit,
   output logic                                  squash,
   output logic [cpu7_csr_pkg::ECODE_W-1:0]      excp_ecode,

   // registered fetch redirect
   output logic                                  redirect_valid,
   output logic [cpu7_csr_pkg::GRLEN-1:0]        redirect_pc
);

   import cpu7_csr_pkg::*;

   logic excp_present;

   // any exception source at the execute stage
   assign excp_present = ale_e || illinst_e;

   // exception wins over ertn
   assign excp_commit = excp_present;
   assign ertn_commit = ertn_e && !excp_present;

   // csr writes die with the excepting instruction
   assign squash = excp_commit;

   // illegal instruction is reported over address error
   assign excp_ecode = illinst_e ? ECODE_INE : ECODE_ALE;

   // one pulse per committed event
   always_ff @(posedge clk) begin
      if (reset) begin
         redirect_valid <= 1'b0;
      end else begin
         redirect_valid <= excp_commit || ertn_commit;
      end
   end

   // target sampled from the csrs as they are in the event cycle
   always_ff @(posedge clk) begin
      if (excp_commit) begin
         redirect_pc <= csr_eentry;
      end else if (ertn_commit) begin
         redirect_pc <= csr_era;
      end
   end

endmodule

//--- sim/tb_cpu7_csr_top.sv
`timescale 1ns/1ps

module tb_cpu7_csr_top;

   import cpu7_csr_pkg::*;

   localparam int REDIRECT_TIMEOUT = 8;

   logic clk, reset, csr_op_valid, ale_e, illinst_e, ertn_e;
   logic [CSR_OP_W-1:0] csr_op;
   logic [CSR_NUM_W-1:0] csr_num;
   logic [GRLEN-1:0] csr_rd_value, csr_rj_value, pc_e;
   logic [GRLEN-1:0] csr_result, redirect_pc;
   logic redirect_valid, eeprom_flush;

   // reference model of the six registers, stored as read values
   logic [31:0] m_crmd, m_prmd, m_estat, m_era, m_eentry, m_bsec;
   logic [31:0] rng_state;
   int error_count;
   int check_count;

   cpu7_csr_top i_cpu7_csr_top (
      .clk(clk), .reset(reset), .csr_op_valid(csr_op_valid), .csr_op(csr_op),
      .csr_num(csr_num), .csr_rd_value(csr_rd_value), .csr_rj_value(csr_rj_value),
      .ale_e(ale_e), .illinst_e(illinst_e), .ertn_e(ertn_e), .pc_e(pc_e),
      .csr_result(csr_result), .redirect_valid(redirect_valid),
      .redirect_pc(redirect_pc), .eeprom_flush(eeprom_flush)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, actual, expected);
      end
   endtask

   // bits that software can change in each csr
   function automatic logic [31:0] wr_bits(input logic [CSR_NUM_W-1:0] num);
      case (num)
         CSR_CRMD, CSR_PRMD: return 32'h0000_0007;
         CSR_ESTAT:          return 32'h003f_0000;
         CSR_ERA:            return 32'hffff_ffff;
         CSR_EENTRY:         return 32'hffff_ffc0;
         default:            return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] model_read(input logic [CSR_NUM_W-1:0] num);
      case (num)
         CSR_CRMD:   return m_crmd;
         CSR_PRMD:   return m_prmd;
         CSR_ESTAT:  return m_estat;
         CSR_ERA:    return m_era;
         CSR_EENTRY: return m_eentry;
         CSR_BSEC:   return m_bsec;
         default:    return 32'h0;
      endcase
   endfunction

   task automatic model_write(input logic [CSR_NUM_W-1:0] num, input logic [31:0] data,
                              input logic [31:0] mask);
      logic [31:0] w;
      logic [31:0] nv;
      w  = mask & wr_bits(num);
      nv = (model_read(num) & ~w) | (data & w);
      case (num)
         CSR_CRMD:   m_crmd = nv;
         CSR_PRMD:   m_prmd = nv;
         CSR_ESTAT:  m_estat = nv;
         CSR_ERA:    m_era = nv;
         CSR_EENTRY: m_eentry = nv;
         // ef only ever goes from 0 to 1
         CSR_BSEC:   if (mask[0] && data[0]) m_bsec = 32'h1;
         default:    ;
      endcase
   endtask

   task automatic drive(input logic valid, input logic [CSR_OP_W-1:0] op,
                        input logic [CSR_NUM_W-1:0] num, input logic [31:0] rd,
                        input logic [31:0] rj, input logic ale, input logic ill,
                        input logic ertn, input logic [31:0] pc);
      @(posedge clk);
      csr_op_valid <= valid;
      csr_op       <= op;
      csr_num      <= num;
      csr_rd_value <= rd;
      csr_rj_value <= rj;
      ale_e        <= ale;
      illinst_e    <= ill;
      ertn_e       <= ertn;
      pc_e         <= pc;
   endtask

   task automatic drive_idle();
      drive(1'b0, CSR_OP_RD, 14'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      m_crmd   = 32'h0;
      m_prmd   = 32'h0;
      m_estat  = 32'h0;
      m_era    = 32'h0;
      m_eentry = 32'h0;
      m_bsec   = 32'h0;
   endtask

   // one csr instruction, result compared with the old model value
   task automatic csr_access(input logic [CSR_OP_W-1:0] op, input logic [CSR_NUM_W-1:0] num,
                             input logic [31:0] rd, input logic [31:0] rj, input string name);
      logic [31:0] expected;
      expected = model_read(num);
      drive(1'b1, op, num, rd, rj, 1'b0, 1'b0, 1'b0, 32'h0);
      @(negedge clk);
      check(name, csr_result, expected);
      if (op == CSR_OP_WR) model_write(num, rd, 32'hffff_ffff);
      else if (op == CSR_OP_XCHG) model_write(num, rd, rj);
      drive_idle();
   endtask

   task automatic csr_read(input logic [CSR_NUM_W-1:0] num, input string name);
      csr_access(CSR_OP_RD, num, 32'h0, 32'h0, name);
   endtask

   // event cycle, optionally with a csrwr alongside, then the redirect pulse
   task automatic run_event(input logic wr_valid, input logic [CSR_NUM_W-1:0] wr_num,
                            input logic [31:0] wr_data, input logic ale, input logic ill,
                            input logic ertn, input logic [31:0] pc);
      logic [31:0] exp_pc;
      int waited;
      exp_pc = (ale || ill) ? m_eentry : m_era;
      drive(wr_valid, CSR_OP_WR, wr_num, wr_data, 32'h0, ale, ill, ertn, pc);
      if (ale || ill) begin
         m_prmd  = m_crmd & 32'h7;
         m_crmd  = 32'h0;
         m_era   = pc;
         m_estat = ill ? 32'h000d_0000 : 32'h0009_0000;
      end else if (ertn) begin
         m_crmd = m_prmd;
      end else if (wr_valid) begin
         model_write(wr_num, wr_data, 32'hffff_ffff);
      end
      drive_idle();
      waited = 0;
      @(negedge clk);
      while (!redirect_valid && waited < REDIRECT_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!redirect_valid) begin
         error_count++;
         $display("redirect never arrived within %0d cycles", REDIRECT_TIMEOUT);
      end else begin
         check("redirect_latency", waited, 32'h0);
         check("redirect_pc", redirect_pc, exp_pc);
         @(negedge clk);
         check("redirect_valid", {31'b0, redirect_valid}, 32'h0);
      end
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      check("eeprom_flush", {31'b0, eeprom_flush}, 32'h0);
      check("redirect_valid", {31'b0, redirect_valid}, 32'h0);
      csr_read(CSR_CRMD, "crmd");
      csr_read(CSR_PRMD, "prmd");
      csr_read(CSR_ESTAT, "estat");
      csr_read(CSR_ERA, "era");
      csr_read(CSR_EENTRY, "eentry");
      csr_read(CSR_BSEC, "bsec");
      csr_read(14'h002, "unmapped_002");
      csr_read(14'h3ff, "unmapped_3ff");
   endtask

   task automatic exercise_writes();
      logic [CSR_NUM_W-1:0] num;
      logic [31:0] data;
      csr_access(CSR_OP_WR, CSR_CRMD, 32'hffff_fffd, 32'h0, "crmd_old");
      csr_read(CSR_CRMD, "crmd");
      csr_access(CSR_OP_WR, CSR_PRMD, 32'h0000_0006, 32'h0, "prmd_old");
      csr_read(CSR_PRMD, "prmd");
      csr_access(CSR_OP_WR, CSR_ERA, 32'h1c00_0a5c, 32'h0, "era_old");
      csr_read(CSR_ERA, "era");
      csr_access(CSR_OP_WR, CSR_EENTRY, 32'h1c00_803f, 32'h0, "eentry_old");
      csr_read(CSR_EENTRY, "eentry");
      for (int i = 0; i < 15; i++) begin
         case (i % 5)
            0: num = CSR_CRMD;
            1: num = CSR_PRMD;
            2: num = CSR_ESTAT;
            3: num = CSR_ERA;
            default: num = CSR_EENTRY;
         endcase
         rng_state = xorshift32(rng_state);
         data = rng_state;
         rng_state = xorshift32(rng_state);
         csr_access(CSR_OP_XCHG, num, data, rng_state, "xchg_old");
         csr_read(num, "xchg_new");
      end
   endtask

   task automatic take_exception();
      csr_access(CSR_OP_WR, CSR_CRMD, 32'h0000_0007, 32'h0, "crmd_old");
      // prmd cleared so the saved crmd fields show up
      csr_access(CSR_OP_WR, CSR_PRMD, 32'h0000_0000, 32'h0, "prmd_old");
      csr_access(CSR_OP_WR, CSR_EENTRY, 32'h1c00_8000, 32'h0, "eentry_old");
      run_event(1'b0, CSR_CRMD, 32'h0, 1'b1, 1'b0, 1'b0, 32'h1c00_1234);
      csr_read(CSR_CRMD, "crmd");
      csr_read(CSR_PRMD, "prmd");
      csr_read(CSR_ERA, "era");
      csr_read(CSR_ESTAT, "estat");
      run_event(1'b0, CSR_CRMD, 32'h0, 1'b1, 1'b1, 1'b0, 32'h1c00_2000);
      csr_read(CSR_ESTAT, "estat");
      csr_read(CSR_ERA, "era");
   endtask

   task automatic return_from_exception();
      csr_access(CSR_OP_WR, CSR_PRMD, 32'h0000_0005, 32'h0, "prmd_old");
      csr_access(CSR_OP_WR, CSR_ERA, 32'h1c00_3008, 32'h0, "era_old");
      run_event(1'b0, CSR_CRMD, 32'h0, 1'b0, 1'b0, 1'b1, 32'h1c00_8010);
      csr_read(CSR_CRMD, "crmd");
      // exception wins over ertn
      run_event(1'b0, CSR_CRMD, 32'h0, 1'b1, 1'b0, 1'b1, 32'h1c00_4000);
      csr_read(CSR_CRMD, "crmd");
      csr_read(CSR_PRMD, "prmd");
      csr_read(CSR_ERA, "era");
      csr_read(CSR_ESTAT, "estat");
   endtask

   task automatic squash_write();
      run_event(1'b1, CSR_EENTRY, 32'h2000_0000, 1'b1, 1'b0, 1'b0, 32'h1c00_5004);
      csr_read(CSR_EENTRY, "eentry");
   endtask

   task automatic sticky_flush();
      csr_access(CSR_OP_WR, CSR_BSEC, 32'h0000_0001, 32'h0, "bsec_old");
      @(negedge clk);
      check("eeprom_flush", {31'b0, eeprom_flush}, 32'h1);
      csr_access(CSR_OP_WR, CSR_BSEC, 32'h0000_0000, 32'h0, "bsec_old");
      csr_read(CSR_BSEC, "bsec");
      @(negedge clk);
      check("eeprom_flush", {31'b0, eeprom_flush}, 32'h1);
      apply_reset();
      @(negedge clk);
      check("eeprom_flush", {31'b0, eeprom_flush}, 32'h0);
      csr_read(CSR_BSEC, "bsec");
   endtask

   initial begin
      reset = 1'b1;
      csr_op_valid = 1'b0;
      csr_op = CSR_OP_RD;
      csr_num = '0;
      csr_rd_value = '0;
      csr_rj_value = '0;
      ale_e = 1'b0;
      illinst_e = 1'b0;
      ertn_e = 1'b0;
      pc_e = '0;
      error_count = 0;
      check_count = 0;
      rng_state = 32'h981ea6d8;
      apply_reset();
      check_reset_state();
      exercise_writes();
      take_exception();
      return_from_exception();
      squash_write();
      sticky_flush();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // guard against a stuck run
   initial begin
      #100000;
      $display("simulation ran past its time limit");
      $display("Test failed");
      $finish;
   end

endmodule
